//--- rtl/exec_pkg.sv
// Execute pipeline shared types
`default_nettype none

package exec_pkg;

	localparam int XLEN       = 32; // Datapath width
	localparam int REG_ADDR_W = 5;  // General register address field
	localparam int CSR_ADDR_W = 12; // CSR address field

	typedef enum logic [3:0] {
		OP_NOP    = 4'd0,
		OP_ADD    = 4'd1,
		OP_SUB    = 4'd2,
		OP_AND    = 4'd3,
		OP_OR     = 4'd4,
		OP_XOR    = 4'd5,
		OP_ADDI   = 4'd6,
		OP_CSRRW  = 4'd7,
		OP_CSRRS  = 4'd8,
		OP_CSRRWI = 4'd9  // Codes 10..15 decode as no-ops
	} opcode_e;

	typedef enum logic [1:0] {
		REG_GPR  = 2'd0, // Operates on general registers
		REG_CSR  = 2'd1, // Reads and writes a CSR
		REG_NONE = 2'd2  // No register activity
	} reg_type_e;

	typedef struct packed {
		opcode_e                opcode; // Bits 31..28
		logic [REG_ADDR_W-1:0]  rd;     // Bits 27..23
		logic [REG_ADDR_W-1:0]  rs1;    // Bits 22..18
		logic [REG_ADDR_W-1:0]  rs2;    // Bits 17..13
		logic                   unused; // Bit 12
		logic [CSR_ADDR_W-1:0]  imm;    // Immediate or CSR address
	} instr_t;

	typedef struct packed {
		logic                   valid;
		opcode_e                opcode;
		logic [REG_ADDR_W-1:0]  rd;
		logic [REG_ADDR_W-1:0]  rs1;
		logic [REG_ADDR_W-1:0]  rs2;
		reg_type_e              reg_type;
		logic                   csr_imm;   // Operand A is the rs1 field itself
		logic [CSR_ADDR_W-1:0]  csr_addr;
		logic [XLEN-1:0]        imm;       // Zero extended
		logic [XLEN-1:0]        rda;       // Register file read at issue
		logic [XLEN-1:0]        rdb;
		logic                   reg_write;
		logic                   csr_write;
	} idex_t;

	typedef struct packed {
		logic                   valid;
		logic [REG_ADDR_W-1:0]  rd;
		logic                   reg_write;
		reg_type_e              reg_type;
		logic [XLEN-1:0]        alu_out;   // Value for rd
		logic [CSR_ADDR_W-1:0]  csr_addr;
		logic                   csr_write;
		logic [XLEN-1:0]        csr_wdata; // New CSR value
	} exmem_t;

	typedef exmem_t memwb_t; // WB carries the same fields

endpackage

`default_nettype wire

//--- rtl/issue_decode.sv
// Instruction decode and operand read
`timescale 1ns/1ps
`default_nettype none

module issue_decode import exec_pkg::*; (
	input  wire [XLEN-1:0]        instr,    // Raw word from the bus
	input  wire                   issue,    // Word accepted on this edge
	output logic [REG_ADDR_W-1:0] rs1_addr, // Register file port A
	output logic [REG_ADDR_W-1:0] rs2_addr, // Register file port B
	input  wire [XLEN-1:0]        rs1_data,
	input  wire [XLEN-1:0]        rs2_data,
	output idex_t                 uop       // Micro-op for ID/EX
);

	instr_t f; // Field view of the word

	assign f        = instr;
	assign rs1_addr = f.rs1; // Read ports follow the raw fields
	assign rs2_addr = f.rs2;

	always_comb begin
		uop          = '0;
		uop.valid    = issue;
		uop.opcode   = f.opcode;
		uop.rd       = f.rd;
		uop.rs1      = f.rs1;
		uop.rs2      = f.rs2;
		uop.csr_addr = f.imm;            // Same bits serve as CSR address
		uop.imm      = XLEN'(f.imm);     // Zero extend
		uop.rda      = rs1_data;
		uop.rdb      = rs2_data;
		uop.reg_type = REG_NONE;
		case (f.opcode)
			OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI: begin
				uop.reg_type  = REG_GPR;
				uop.reg_write = issue && (f.rd != '0); // x0 is never written
			end
			OP_CSRRW, OP_CSRRS, OP_CSRRWI: begin
				uop.reg_type  = REG_CSR;
				uop.reg_write = issue && (f.rd != '0); // Old CSR value to rd
				uop.csr_write = issue;
				uop.csr_imm   = (f.opcode == OP_CSRRWI);
			end
			default: begin
				uop.reg_type = REG_NONE; // NOP and spare codes write nothing
			end
		endcase
	end

endmodule

`default_nettype wire

//--- rtl/reg_file.sv
// General register file
`timescale 1ns/1ps
`default_nettype none

module reg_file import exec_pkg::*; (
	input  wire                   clk,
	input  wire                   arst_n,
	input  wire [REG_ADDR_W-1:0]  rd_addr_a,
	input  wire [REG_ADDR_W-1:0]  rd_addr_b,
	output logic [XLEN-1:0]       rd_data_a,
	output logic [XLEN-1:0]       rd_data_b,
	input  wire                   wr_en,
	input  wire [REG_ADDR_W-1:0]  wr_addr,
	input  wire [XLEN-1:0]        wr_data,
	input  wire [REG_ADDR_W-1:0]  dbg_addr, // Bus read port
	output logic [XLEN-1:0]       dbg_data
);

	logic [XLEN-1:0] regs [2**REG_ADDR_W]; // Entry 0 stays zero
	logic            wr_live;              // Write to a real register this cycle

	assign wr_live = wr_en && (wr_addr != '0);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 2**REG_ADDR_W; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_live) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// Write-through covers the instruction three ahead
	assign rd_data_a = (wr_live && wr_addr == rd_addr_a) ? wr_data : regs[rd_addr_a];
	assign rd_data_b = (wr_live && wr_addr == rd_addr_b) ? wr_data : regs[rd_addr_b];
	assign dbg_data  = regs[dbg_addr];

endmodule

`default_nettype wire

//--- rtl/csr_file.sv
// CSR storage array
`timescale 1ns/1ps
`default_nettype none

module csr_file import exec_pkg::*; #(
	parameter int CSR_ADDR_BITS = 2 // Entries are 2**CSR_ADDR_BITS
) (
	input  wire                      clk,
	input  wire                      arst_n,
	input  wire [CSR_ADDR_BITS-1:0]  rd_addr,  // EX stage read
	output logic [XLEN-1:0]          rd_data,
	input  wire                      wr_en,    // WB stage write
	input  wire [CSR_ADDR_BITS-1:0]  wr_addr,
	input  wire [XLEN-1:0]           wr_data,
	input  wire [CSR_ADDR_BITS-1:0]  dbg_addr, // Bus read port
	output logic [XLEN-1:0]          dbg_data
);

	logic [XLEN-1:0] csrs [2**CSR_ADDR_BITS];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 2**CSR_ADDR_BITS; i++) begin
				csrs[i] <= '0;
			end
		end else if (wr_en) begin
			csrs[wr_addr] <= wr_data;
		end
	end

	// The bypass unit forwards the entry that WB is writing
	assign rd_data  = csrs[rd_addr];
	assign dbg_data = csrs[dbg_addr];

endmodule

`default_nettype wire

//--- rtl/control_bypass_ex.sv
// EX stage operand bypass
`timescale 1ns/1ps
`default_nettype none

module control_bypass_ex import exec_pkg::*; (
	input  wire idex_t       idex,     // Instruction in EX
	input  wire exmem_t      exmem,    // One ahead
	input  wire memwb_t      memwb,    // Two ahead and writing this cycle
	input  wire [XLEN-1:0]   csr_data, // CSR array read in EX
	output logic [XLEN-1:0]  bypass_a,
	output logic [XLEN-1:0]  bypass_b
);

	typedef enum logic [1:0] {
		SRC_IDEX  = 2'd0, // Value captured at issue
		SRC_MEMWB = 2'd1,
		SRC_EXMEM = 2'd2
	} bypass_src_e;

	bypass_src_e sel_a;
	bypass_src_e sel_b;
	logic        csr_op; // B is a CSR value

	// Newest older stage writing a nonzero matching rd
	function automatic bypass_src_e gpr_src(input logic [REG_ADDR_W-1:0] rs,
	                                        input exmem_t em, input memwb_t mw);
		if (em.reg_write && em.rd != '0 && em.rd == rs) begin
			return SRC_EXMEM;
		end else if (mw.reg_write && mw.rd != '0 && mw.rd == rs) begin
			return SRC_MEMWB;
		end
		return SRC_IDEX;
	endfunction

	assign csr_op = (idex.reg_type == REG_CSR);
	assign sel_a  = gpr_src(idex.rs1, exmem, memwb);

	always_comb begin
		sel_b = SRC_IDEX;
		if (csr_op) begin
			if (exmem.csr_write && exmem.csr_addr == idex.csr_addr) begin
				sel_b = SRC_EXMEM; // EX/MEM wins over MEM/WB
			end else if (memwb.csr_write && memwb.csr_addr == idex.csr_addr) begin
				sel_b = SRC_MEMWB;
			end
		end else if (idex.reg_type == REG_GPR) begin
			sel_b = gpr_src(idex.rs2, exmem, memwb);
		end
	end

	always_comb begin
		if (idex.csr_imm) begin
			bypass_a = XLEN'(idex.rs1); // Immediate form uses the field
		end else begin
			case (sel_a)
				SRC_EXMEM: bypass_a = exmem.alu_out;
				SRC_MEMWB: bypass_a = memwb.alu_out;
				default:   bypass_a = idex.rda;
			endcase
		end
	end

	always_comb begin
		case (sel_b)
			SRC_EXMEM: bypass_b = csr_op ? exmem.csr_wdata : exmem.alu_out;
			SRC_MEMWB: bypass_b = csr_op ? memwb.csr_wdata : memwb.alu_out;
			default:   bypass_b = csr_op ? csr_data : idex.rdb;
		endcase
	end

endmodule

`default_nettype wire

//--- rtl/alu_csr_ex.sv
// Integer ALU and CSR update
`timescale 1ns/1ps
`default_nettype none

module alu_csr_ex import exec_pkg::*; (
	input  wire idex_t      uop,    // Micro-op in EX
	input  wire [XLEN-1:0]  op_a,   // Bypassed operand A
	input  wire [XLEN-1:0]  op_b,   // Bypassed operand B or old CSR
	output exmem_t          result  // Loads EX/MEM
);

	always_comb begin
		result           = '0;
		result.valid     = uop.valid;
		result.rd        = uop.rd;
		result.reg_write = uop.reg_write;
		result.reg_type  = uop.reg_type;
		result.csr_addr  = uop.csr_addr;
		result.csr_write = uop.csr_write;
		case (uop.opcode)
			OP_ADD:  result.alu_out = op_a + op_b;
			OP_SUB:  result.alu_out = op_a - op_b; // Wraps modulo 2**32
			OP_AND:  result.alu_out = op_a & op_b;
			OP_OR:   result.alu_out = op_a | op_b;
			OP_XOR:  result.alu_out = op_a ^ op_b;
			OP_ADDI: result.alu_out = op_a + uop.imm;
			OP_CSRRW, OP_CSRRWI: begin
				result.alu_out   = op_b; // Old CSR to rd
				result.csr_wdata = op_a; // Plain swap
			end
			OP_CSRRS: begin
				result.alu_out   = op_b;
				result.csr_wdata = op_a | op_b; // Set bits from rs1
			end
			default: begin
				result.alu_out = '0; // NOP leaves everything zero
			end
		endcase
	end

endmodule

`default_nettype wire

//--- rtl/exec_pipe_top.sv
// Execute pipeline with Wishbone slave
`timescale 1ns/1ps
`default_nettype none

module exec_pipe_top import exec_pkg::*; #(
	parameter int CSR_ADDR_BITS = 2 // CSR count is 2**CSR_ADDR_BITS
) (
	input  wire              clk,
	input  wire              arst_n,
	input  wire              wb_cyc,
	input  wire              wb_stb,
	input  wire              wb_we,
	input  wire [9:0]        wb_adr,
	input  wire [XLEN-1:0]   wb_dat_w,
	output logic [XLEN-1:0]  wb_dat_r,
	output logic             wb_ack
);

	localparam logic [CSR_ADDR_W-1:0] CSR_MASK = CSR_ADDR_W'((1 << CSR_ADDR_BITS) - 1);

	logic                   req;       // New access whose ack rises next edge
	logic                   issue;     // Instruction write accepted
	logic                   busy;      // Any stage occupied
	logic [XLEN-1:0]        rd_mux;    // Read data before the ack register
	logic [REG_ADDR_W-1:0]  rs1_addr;
	logic [REG_ADDR_W-1:0]  rs2_addr;
	logic [XLEN-1:0]        rs1_data;
	logic [XLEN-1:0]        rs2_data;
	logic [XLEN-1:0]        gpr_dbg;
	logic [XLEN-1:0]        csr_dbg;
	logic [XLEN-1:0]        csr_rd_data;
	logic [XLEN-1:0]        op_a;
	logic [XLEN-1:0]        op_b;
	idex_t                  uop;
	idex_t                  idex_d;
	idex_t                  idex_q;
	exmem_t                 ex_result;
	exmem_t                 exmem_q;
	memwb_t                 memwb_q;

	assign req   = wb_cyc && wb_stb && !wb_ack; // One ack per strobe
	assign issue = req && wb_we && (wb_adr == 10'h000);
	assign busy  = idex_q.valid || exmem_q.valid || memwb_q.valid;

	always_comb begin
		idex_d          = uop;
		idex_d.csr_addr = uop.csr_addr & CSR_MASK; // Aliased CSRs compare equal
	end

	always_comb begin
		rd_mux = '0; // Unmapped reads return zero
		if (wb_adr[9:5] == 5'b00100) begin
			rd_mux = gpr_dbg;              // 0x080 + r
		end else if (wb_adr[9:7] == 3'b010) begin
			rd_mux = csr_dbg;              // 0x100 + c
		end else if (wb_adr == 10'h200) begin
			rd_mux = XLEN'(busy);
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wb_ack  <= 1'b0;
			idex_q  <= '0;
			exmem_q <= '0;
			memwb_q <= '0;
		end else begin
			wb_ack  <= req;
			idex_q  <= idex_d;    // Bubble when nothing issues
			exmem_q <= ex_result;
			memwb_q <= exmem_q;   // MEM slot is a plain stage
		end
	end

	always_ff @(posedge clk) begin
		if (req) begin
			wb_dat_r <= rd_mux; // Valid while ack is high
		end
	end

	issue_decode issue_decode_i (
		.instr    (wb_dat_w),
		.issue    (issue),
		.rs1_addr (rs1_addr),
		.rs2_addr (rs2_addr),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data),
		.uop      (uop)
	);

	reg_file reg_file_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.rd_addr_a (rs1_addr),
		.rd_addr_b (rs2_addr),
		.rd_data_a (rs1_data),
		.rd_data_b (rs2_data),
		.wr_en     (memwb_q.reg_write),
		.wr_addr   (memwb_q.rd),
		.wr_data   (memwb_q.alu_out),
		.dbg_addr  (wb_adr[REG_ADDR_W-1:0]),
		.dbg_data  (gpr_dbg)
	);

	csr_file #(.CSR_ADDR_BITS(CSR_ADDR_BITS)) csr_file_i (
		.clk      (clk),
		.arst_n   (arst_n),
		.rd_addr  (idex_q.csr_addr[CSR_ADDR_BITS-1:0]),
		.rd_data  (csr_rd_data),
		.wr_en    (memwb_q.csr_write),
		.wr_addr  (memwb_q.csr_addr[CSR_ADDR_BITS-1:0]),
		.wr_data  (memwb_q.csr_wdata),
		.dbg_addr (wb_adr[CSR_ADDR_BITS-1:0]),
		.dbg_data (csr_dbg)
	);

	control_bypass_ex control_bypass_ex_i (
		.idex     (idex_q),
		.exmem    (exmem_q),
		.memwb    (memwb_q),
		.csr_data (csr_rd_data),
		.bypass_a (op_a),
		.bypass_b (op_b)
	);

	alu_csr_ex alu_csr_ex_i (
		.uop    (idex_q),
		.op_a   (op_a),
		.op_b   (op_b),
		.result (ex_result)
	);

endmodule

`default_nettype wire

//--- testbench/tb_exec_pipe.sv
// Execute pipeline testbench
`timescale 1ns/1ps
`default_nettype none

module tb_exec_pipe import exec_pkg::*; ();

	localparam int CSR_BITS = 2;             // Passed down to the DUT
	localparam int CSR_N    = 1 << CSR_BITS;
	localparam int MAX_CYC  = 4000;          // Generous bound on the test length
	localparam int RAND_LEN = 200;

	logic        clk = 1'b0;
	logic        arst_n;
	logic        wb_cyc;
	logic        wb_stb;
	logic        wb_we;
	logic [9:0]  wb_adr;
	logic [31:0] wb_dat_w;
	logic [31:0] wb_dat_r;
	logic        wb_ack;

	logic [31:0] m_gpr [32];         // Reference register state
	logic [31:0] m_csr [CSR_N];      // Reference CSR state
	logic [31:0] lcg_state = 32'd79; // Random seed
	int          mismatch_cnt = 0;
	int          other_cnt = 0;
	int          cycle_cnt = 0;
	int          last_issue_cyc = 0; // Ack cycle of the newest issue
	int          last_ack_cyc = 0;
	logic        issue_pending = 1'b0;

	exec_pipe_top #(.CSR_ADDR_BITS(CSR_BITS)) exec_pipe_top_i (
		.clk      (clk),
		.arst_n   (arst_n),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_dat_r (wb_dat_r),
		.wb_ack   (wb_ack)
	);

	always #2 clk = ~clk; // 4 ns period

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= MAX_CYC) begin
			$display("Timeout: run stopped after %0d cycles", cycle_cnt);
			$display("Errors: %0d mismatches, %0d other", mismatch_cnt, other_cnt + 1);
			$display("Simulation failed");
			$finish;
		end
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state >> 16; // Upper bits have the longer period
	endfunction

	function automatic logic [31:0] make_instr(input logic [3:0] op, input logic [4:0] rd,
		input logic [4:0] rs1, input logic [4:0] rs2, input logic [11:0] imm);
		return {op, rd, rs1, rs2, 1'b0, imm};
	endfunction

	// Sequential model that runs one instruction at a time
	task automatic model_exec(input logic [31:0] instr);
		logic [3:0]          op;
		logic [4:0]          rd;
		logic [4:0]          rs1;
		logic [4:0]          rs2;
		logic [11:0]         imm;
		logic [CSR_BITS-1:0] ci;
		logic [31:0]         a;
		logic [31:0]         b;
		logic [31:0]         old;
		logic [31:0]         res;
		logic                wr;
		op  = instr[31:28];
		rd  = instr[27:23];
		rs1 = instr[22:18];
		rs2 = instr[17:13];
		imm = instr[11:0];
		ci  = imm[CSR_BITS-1:0]; // Addresses wrap modulo the count
		a   = m_gpr[rs1];
		b   = m_gpr[rs2];
		old = m_csr[ci];
		res = '0;
		wr  = 1'b1;
		case (op)
			OP_ADD:  res = a + b;
			OP_SUB:  res = a - b;
			OP_AND:  res = a & b;
			OP_OR:   res = a | b;
			OP_XOR:  res = a ^ b;
			OP_ADDI: res = a + {20'd0, imm};
			OP_CSRRW: begin
				res       = old;
				m_csr[ci] = a;
			end
			OP_CSRRS: begin
				res       = old;
				m_csr[ci] = a | old;
			end
			OP_CSRRWI: begin
				res       = old;
				m_csr[ci] = {27'd0, rs1}; // Field itself is the value
			end
			default: wr = 1'b0; // NOP and spare codes
		endcase
		if (wr && rd != 5'd0) begin
			m_gpr[rd] = res;
		end
	endtask

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp) else begin
			mismatch_cnt++;
			$display("Mismatch %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	// One classic bus cycle driven on the falling edge
	task automatic wb_access(input logic we, input logic [9:0] adr, input logic [31:0] wdat,
		output logic [31:0] rdat);
		int waited;
		waited   = 0;
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = adr;
		wb_dat_w = wdat;
		do begin
			@(negedge clk);
			waited++;
		end while (!wb_ack && waited < 8);
		rdat         = wb_dat_r; // Stable between edges
		last_ack_cyc = cycle_cnt;
		assert (wb_ack && waited == 1) else begin
			other_cnt++;
			$display("Ack for address %h not seen one cycle after strobe (%0d waited)",
			         adr, waited);
		end
		if (we && adr == 10'h000) begin
			last_issue_cyc = cycle_cnt;
			issue_pending  = 1'b1;
		end
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
		@(negedge clk);
		assert (!wb_ack) else begin
			other_cnt++;
			$display("Ack for address %h stayed high longer than one cycle", adr);
		end
	endtask

	task automatic wb_write(input logic [9:0] adr, input logic [31:0] dat);
		logic [31:0] unused_rd;
		wb_access(1'b1, adr, dat, unused_rd);
	endtask

	task automatic wb_read(input logic [9:0] adr, output logic [31:0] dat);
		wb_access(1'b0, adr, 32'd0, dat);
	endtask

	task automatic issue_instr(input logic [31:0] instr);
		wb_write(10'h000, instr);
		model_exec(instr);
	endtask

	// Poll busy and then check the drain time
	task automatic wait_idle();
		logic [31:0] b;
		wb_read(10'h200, b);
		while (b != 32'd0) begin
			wb_read(10'h200, b);
		end
		if (issue_pending) begin
			assert (last_ack_cyc - last_issue_cyc <= 4) else begin
				other_cnt++;
				$display("Busy still high %0d cycles after the last issue",
				         last_ack_cyc - last_issue_cyc);
			end
		end
		issue_pending = 1'b0;
	endtask

	task automatic check_all(input string name);
		logic [31:0] d;
		for (int r = 0; r < 32; r++) begin
			wb_read(10'h080 + 10'(r), d);
			check_value($sformatf("%s x%0d", name, r), m_gpr[r], d);
		end
		for (int c = 0; c < CSR_N; c++) begin
			wb_read(10'h100 + 10'(c), d);
			check_value($sformatf("%s csr%0d", name, c), m_csr[c], d);
		end
	endtask

	initial begin
		logic [31:0] d;
		logic [31:0] r;
		arst_n   = 1'b0;
		wb_cyc   = 1'b0;
		wb_stb   = 1'b0;
		wb_we    = 1'b0;
		wb_adr   = '0;
		wb_dat_w = '0;
		for (int i = 0; i < 32; i++) begin
			m_gpr[i] = '0;
		end
		for (int i = 0; i < CSR_N; i++) begin
			m_csr[i] = '0;
		end
		repeat (3) @(negedge clk);
		arst_n = 1'b1;

		// Reset state and x0 writes
		wb_read(10'h200, d);
		check_value("reset busy", 32'd0, d);
		check_all("reset");
		issue_instr(make_instr(OP_ADDI, 5'd0, 5'd0, 5'd0, 12'd5));
		issue_instr(make_instr(OP_CSRRW, 5'd0, 5'd0, 5'd0, 12'd0));
		wait_idle();
		check_all("x0 write");

		// Dependent chains at distance 1, 2 and 3
		issue_instr(make_instr(OP_ADDI, 5'd1, 5'd0, 5'd0, 12'd100));
		issue_instr(make_instr(OP_ADD, 5'd2, 5'd1, 5'd1, 12'd0));
		issue_instr(make_instr(OP_ADDI, 5'd3, 5'd0, 5'd0, 12'd7));
		issue_instr(make_instr(OP_XOR, 5'd4, 5'd2, 5'd3, 12'd0));
		issue_instr(make_instr(OP_ADDI, 5'd6, 5'd0, 5'd0, 12'd3));
		issue_instr(make_instr(OP_NOP, 5'd0, 5'd0, 5'd0, 12'd0));
		issue_instr(make_instr(OP_NOP, 5'd0, 5'd0, 5'd0, 12'd0));
		issue_instr(make_instr(OP_OR, 5'd5, 5'd6, 5'd4, 12'd0));
		wait_idle();
		check_all("forwarding");

		// Every ALU opcode with SUB going below zero
		issue_instr(make_instr(OP_AND, 5'd7, 5'd2, 5'd4, 12'd0));
		issue_instr(make_instr(OP_OR, 5'd8, 5'd7, 5'd1, 12'd0));
		issue_instr(make_instr(OP_XOR, 5'd9, 5'd8, 5'd8, 12'd0));
		issue_instr(make_instr(OP_SUB, 5'd10, 5'd0, 5'd1, 12'd0));
		issue_instr(make_instr(OP_SUB, 5'd11, 5'd10, 5'd2, 12'd0));
		issue_instr(make_instr(OP_ADDI, 5'd12, 5'd11, 5'd0, 12'hfff));
		wait_idle();
		check_all("alu");

		// CSR chains including aliased addresses
		issue_instr(make_instr(OP_CSRRWI, 5'd13, 5'd21, 5'd0, 12'd1));
		issue_instr(make_instr(OP_CSRRS, 5'd14, 5'd1, 5'd0, 12'd1));
		issue_instr(make_instr(OP_CSRRW, 5'd15, 5'd2, 5'd0, 12'd0));
		issue_instr(make_instr(OP_CSRRS, 5'd16, 5'd12, 5'd0, 12'd1));
		issue_instr(make_instr(OP_CSRRW, 5'd17, 5'd10, 5'd0, 12'h006));
		issue_instr(make_instr(OP_CSRRS, 5'd18, 5'd0, 5'd0, 12'd2));
		issue_instr(make_instr(OP_CSRRWI, 5'd0, 5'd9, 5'd0, 12'd3));
		issue_instr(make_instr(OP_CSRRS, 5'd19, 5'd0, 5'd0, 12'h007));
		wait_idle();
		check_all("csr");

		// Random program on a small register pool
		for (int n = 0; n < RAND_LEN; n++) begin
			r = lcg_next();
			d = lcg_next();
			issue_instr(make_instr(r[3:0], {2'b00, r[6:4]} % 5'd5, {2'b00, r[9:7]} % 5'd5,
				{2'b00, r[12:10]} % 5'd5, d[11:0]));
		end
		wait_idle();
		check_all("random");

		$display("Errors: %0d mismatches, %0d other", mismatch_cnt, other_cnt);
		if (mismatch_cnt == 0 && other_cnt == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- exec_pipe_top.f
rtl/exec_pkg.sv
rtl/issue_decode.sv
rtl/reg_file.sv
rtl/csr_file.sv
rtl/control_bypass_ex.sv
rtl/alu_csr_ex.sv
rtl/exec_pipe_top.sv
testbench/tb_exec_pipe.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
	-f exec_pipe_top.f --top-module tb_exec_pipe -o sim_exec_pipe \
	&& ./obj_dir/sim_exec_pipe > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Simulation passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
